// ==== src/game_params.svh ====
// Size constants for the four-lane note sequencer
// Include where lane, slot or song lengths are needed
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// Playfield layout
`define NUM_LANES 4
`define SLOTS_PER_LANE 20

// Song and tail lengths, in shift steps
`define SONG_STEPS 82
`define TAIL_STEPS 15

`endif

// ==== src/sequencer_pkg.sv ====
// Types for game sequencing: phase state and step position
// Import where the game state or the step counter is handled
`default_nettype none

package sequencer_pkg;

	// Game phases
	// END_HOLD waits for space press, END_RELEASE for its release
	typedef enum logic [2:0] {
		INTRO,
		READY,
		PLAY,
		TAIL,
		END_HOLD,
		END_RELEASE
	} game_state_t;

	// Step index within a song or within the tail
	typedef logic [6:0] step_t;

endpackage

`default_nettype wire

// ==== src/chart_pkg.sv ====
// Types for note output: lane, slot, song select and lane trigger vector
// Import where chart entries are looked up or triggers are driven
`default_nettype none

`include "game_params.svh"

package chart_pkg;

	// Lane and slot indices, both stored minus one
	typedef logic [1:0] lane_t;
	typedef logic [4:0] slot_t;

	// 0 selects song 1, 1 selects song 2
	typedef logic song_t;

	// One-hot slot triggers of a single lane
	typedef logic [`SLOTS_PER_LANE-1:0] lane_trig_t;

endpackage

`default_nettype wire

// ==== src/sequence_if.sv ====
// Control bundle between the game FSM, the step counter and the chart
// FSM drives phase controls, counter returns position and end-of-phase
`timescale 1ns/1ps
`default_nettype none

interface sequence_if;
	import sequencer_pkg::*;
	import chart_pkg::*;

	// FSM side
	logic  clear;
	logic  advance;
	logic  tail;
	logic  play;
	song_t song;

	// Counter side
	step_t step;
	logic  last;

	modport fsm_mp (output clear, advance, tail, play, song, input last);
	modport cnt_mp (input clear, advance, tail, output step, last);
	modport chart_mp (input play, song, step);

endinterface

`default_nettype wire

// ==== src/game_fsm.sv ====
// Game phase FSM: intro, ready, play, tail and the end screen
// Chooses the song and tells the step counter when to clear or advance
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
	input  logic Clk,
	input  logic rst_n,
	input  logic one,
	input  logic two,
	input  logic shift,
	input  logic space,
	sequence_if.fsm_mp seq,
	output sequencer_pkg::game_state_t state
);
	import sequencer_pkg::*;
	import chart_pkg::*;

	game_state_t state_q;
	game_state_t state_d;
	song_t song_q;
	song_t song_d;

	// ------------------------------
	// State and song registers
	// ------------------------------
	always_ff @(posedge Clk)
	begin
		if (!rst_n)
		begin
			state_q <= INTRO;
			song_q  <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			song_q  <= song_d;
		end
	end

	// ------------------------------
	// Next state
	// ------------------------------
	always_comb
	begin
		state_d   = state_q;
		song_d    = song_q;
		seq.clear = 1'b0;
		unique case (state_q)
			// Intro screen lasts one cycle
			INTRO:
				state_d = READY;
			// One beats two when both are pressed
			READY:
				if (one || two)
				begin
					state_d   = PLAY;
					song_d    = one ? 1'b0 : 1'b1;
					seq.clear = 1'b1;
				end
			// Last song step, counter restarts for the tail
			PLAY:
				if (shift && seq.last)
				begin
					state_d   = TAIL;
					seq.clear = 1'b1;
				end
			TAIL:
				if (shift && seq.last)
				begin
					state_d   = END_HOLD;
					seq.clear = 1'b1;
				end
			END_HOLD:
				if (space)
					state_d = END_RELEASE;
			END_RELEASE:
				if (!space)
					state_d = READY;
			default:
				state_d = INTRO;
		endcase
	end

	// Shift only moves play while a song or its tail runs
	assign seq.advance = shift && (state_q == PLAY || state_q == TAIL);
	assign seq.tail    = (state_q == TAIL);
	assign seq.play    = (state_q == PLAY);
	assign seq.song    = song_q;
	assign state       = state_q;

endmodule

`default_nettype wire

// ==== src/step_counter.sv ====
// Step position counter for the song and the tail
// Clears on request, counts shift advances, flags the last step of the phase
`timescale 1ns/1ps
`default_nettype none

`include "game_params.svh"

module step_counter (
	input logic Clk,
	input logic rst_n,
	sequence_if.cnt_mp seq
);
	import sequencer_pkg::*;

	step_t step_q;
	step_t last_step;

	// Clear wins over advance on a phase change
	always_ff @(posedge Clk)
	begin
		if (!rst_n || seq.clear)
			step_q <= '0;
		else if (seq.advance)
			step_q <= step_q + step_t'(1);
	end

	// Phase length picked by tail
	assign last_step = seq.tail ? step_t'(`TAIL_STEPS - 1) : step_t'(`SONG_STEPS - 1);

	assign seq.step = step_q;
	assign seq.last = (step_q == last_step);

endmodule

`default_nettype wire

// ==== src/note_chart.sv ====
// Note chart of both songs
// Looks up the note for the current song step and raises one slot trigger
// Purely combinational, triggers only while a song is playing
`timescale 1ns/1ps
`default_nettype none

`include "game_params.svh"

module note_chart (
	sequence_if.chart_mp seq,
	output chart_pkg::lane_trig_t lane1_trig,
	output chart_pkg::lane_trig_t lane2_trig,
	output chart_pkg::lane_trig_t lane3_trig,
	output chart_pkg::lane_trig_t lane4_trig,
	output logic song_start
);
	import sequencer_pkg::*;
	import chart_pkg::*;

	// Chart entry layout {valid, lane, slot}
	localparam int ENTRY_W = 1 + $bits(lane_t) + $bits(slot_t);

	// Build an entry from 1-based lane and slot
	function automatic logic [ENTRY_W-1:0] nt(input int lane, input int slot);
		nt = {1'b1, lane_t'(lane - 1), slot_t'(slot - 1)};
	endfunction

	// No note on this step
	localparam logic [ENTRY_W-1:0] REST = '0;

	// Song 1 sweeps all slots lane by lane up to this step
	localparam int SWEEP_STEPS = `NUM_LANES * `SLOTS_PER_LANE;

	// ------------------------------
	// Song 2 chart, indexed by step
	// ------------------------------
	localparam logic [ENTRY_W-1:0] SONG2 [`SONG_STEPS] = '{
		nt(2, 1), nt(2, 2), nt(3, 1), nt(3, 2), nt(1, 1),
		nt(2, 3), nt(3, 3), nt(4, 1), nt(1, 2), nt(1, 3),
		nt(4, 2), nt(4, 3), nt(4, 4), nt(3, 4), nt(2, 4),
		nt(1, 4), REST, REST, REST, nt(1, 5),
		nt(1, 6), nt(1, 7), nt(1, 8), REST, nt(3, 5),
		nt(3, 6), REST, nt(2, 5), REST, nt(2, 6),
		nt(4, 5), nt(4, 6), REST, nt(2, 7), nt(2, 8),
		nt(2, 9), REST, REST, nt(4, 7), nt(1, 9),
		nt(4, 8), nt(1, 10), nt(4, 9), nt(1, 11), nt(4, 10),
		nt(1, 12), nt(2, 10), nt(2, 11), nt(3, 7), nt(3, 8),
		nt(4, 11), nt(3, 9), nt(3, 10), REST, REST,
		nt(2, 12), nt(3, 11), nt(4, 12), nt(3, 12), REST,
		REST, nt(4, 13), REST, nt(3, 13), REST,
		nt(2, 13), REST, nt(1, 13), nt(4, 14), nt(4, 15),
		nt(4, 16), nt(4, 17), nt(2, 14), nt(1, 14), nt(3, 14),
		nt(1, 15), nt(3, 15), nt(1, 16), nt(1, 17), nt(1, 18),
		nt(3, 16), nt(3, 17)
	};

	logic [ENTRY_W-1:0] song1_note;
	logic [ENTRY_W-1:0] song2_note;
	logic [ENTRY_W-1:0] note;
	lane_trig_t trig [`NUM_LANES];

	// ------------------------------
	// Note lookup
	// ------------------------------
	always_comb
	begin
		// Song 1 steps through lanes round robin, slot per group of four
		// The two extra steps past the sweep fall back to slot 1
		song1_note = {1'b1, lane_t'(seq.step[1:0]), slot_t'(seq.step[6:2])};
		if (int'(seq.step) >= SWEEP_STEPS)
			song1_note = {1'b1, lane_t'(seq.step[1:0]), slot_t'(0)};

		// Out of range steps never occur in play, treated as rests
		song2_note = REST;
		if (int'(seq.step) < `SONG_STEPS)
			song2_note = SONG2[seq.step];

		note = seq.song ? song2_note : song1_note;
	end

	// ------------------------------
	// One-hot decode per lane
	// ------------------------------
	always_comb
	begin
		for (int l = 0; l < `NUM_LANES; l++)
		begin
			trig[l] = '0;
			// Only the addressed lane fires, only in play
			if (seq.play && note[ENTRY_W-1] && int'(note[ENTRY_W-2 -: 2]) == l)
				trig[l][note[4:0]] = 1'b1;
		end
	end

	assign lane1_trig = trig[0];
	assign lane2_trig = trig[1];
	assign lane3_trig = trig[2];
	assign lane4_trig = trig[3];

	// First step of either song
	assign song_start = seq.play && (seq.step == step_t'(0));

endmodule

`default_nettype wire

// ==== src/rhythm_top.sv ====
// Top level of the note sequencer
// Plain button and shift inputs, per-lane trigger vectors and screen flags out
`timescale 1ns/1ps
`default_nettype none

module rhythm_top (
	input  logic Clk,
	input  logic rst_n,
	input  logic shift,
	input  logic space,
	input  logic one,
	input  logic two,
	output chart_pkg::lane_trig_t lane1_trig,
	output chart_pkg::lane_trig_t lane2_trig,
	output chart_pkg::lane_trig_t lane3_trig,
	output chart_pkg::lane_trig_t lane4_trig,
	output logic intro,
	output logic ready,
	output logic song_start,
	output logic game_over
);
	import sequencer_pkg::*;

	game_state_t state;

	sequence_if seq ();

	// Phase control
	game_fsm u_fsm (
		.Clk   (Clk),
		.rst_n (rst_n),
		.one   (one),
		.two   (two),
		.shift (shift),
		.space (space),
		.seq   (seq),
		.state (state)
	);

	// Song and tail position
	step_counter u_cnt (
		.Clk   (Clk),
		.rst_n (rst_n),
		.seq   (seq)
	);

	// Chart lookup to triggers
	note_chart u_chart (
		.seq        (seq),
		.lane1_trig (lane1_trig),
		.lane2_trig (lane2_trig),
		.lane3_trig (lane3_trig),
		.lane4_trig (lane4_trig),
		.song_start (song_start)
	);

	// Screen flags
	assign intro     = (state == INTRO);
	assign ready     = (state == READY);
	assign game_over = (state == END_HOLD) || (state == END_RELEASE);

endmodule

`default_nettype wire

// ==== verif/rhythm_checker.sv ====
// Reference model and output checks for the note sequencer
// Replays the phase, song and step rules on each rising edge
// Compares every DUT output on the falling edge, counts checks and mismatches
`timescale 1ns/1ps
`default_nettype none

`include "game_params.svh"

module rhythm_checker (
	input  logic Clk,
	input  logic rst_n,
	input  logic shift,
	input  logic space,
	input  logic one,
	input  logic two,
	input  chart_pkg::lane_trig_t lane1_trig,
	input  chart_pkg::lane_trig_t lane2_trig,
	input  chart_pkg::lane_trig_t lane3_trig,
	input  chart_pkg::lane_trig_t lane4_trig,
	input  logic intro,
	input  logic ready,
	input  logic song_start,
	input  logic game_over,
	input  int test_id,
	output int check_count,
	output int error_count
);
	import chart_pkg::*;

	// Model phases
	localparam int S_INTRO = 0;
	localparam int S_READY = 1;
	localparam int S_PLAY = 2;
	localparam int S_TAIL = 3;
	localparam int S_HOLD = 4;
	localparam int S_RELEASE = 5;

	int st = S_INTRO;
	int song = 0;
	int step = 0;
	logic seen_reset = 1'b0;
	int checks = 0;
	int errors = 0;

	// Song 2 chart as lane*100+slot, 0 for a rest
	int song2_tab [`SONG_STEPS] = '{
		201, 202, 301, 302, 101, 203, 303, 401, 102, 103,
		402, 403, 404, 304, 204, 104, 0, 0, 0, 105,
		106, 107, 108, 0, 305, 306, 0, 205, 0, 206,
		405, 406, 0, 207, 208, 209, 0, 0, 407, 109,
		408, 110, 409, 111, 410, 112, 210, 211, 307, 308,
		411, 309, 310, 0, 0, 212, 311, 412, 312, 0,
		0, 413, 0, 313, 0, 213, 0, 113, 414, 415,
		416, 417, 214, 114, 314, 115, 315, 116, 117, 118,
		316, 317
	};

	assign check_count = checks;
	assign error_count = errors;

	function automatic string test_label(input int id);
		case (id)
			0: test_label = "reset_intro";
			1: test_label = "song1";
			2: test_label = "song2";
			3: test_label = "both_buttons";
			4: test_label = "random_run";
			default: test_label = "unknown";
		endcase
	endfunction

	// Expected trigger vector of one lane, 1-based
	function automatic lane_trig_t expected_lane(input int lane);
		int code;
		lane_trig_t v;
		v = '0;
		// Song 1 sweeps lanes round robin, then two extra notes on slot 1
		if (song == 0 && step < `NUM_LANES * `SLOTS_PER_LANE)
			code = (step % 4 + 1) * 100 + step / 4 + 1;
		else if (song == 0)
			code = (step - 79) * 100 + 1;
		else
			code = song2_tab[step];
		if (st == S_PLAY && code / 100 == lane && code % 100 > 0)
			v[code % 100 - 1] = 1'b1;
		return v;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v)
		begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h",
				test_label(test_id), what, exp_v, act_v);
		end
	endtask

	// ------------------------------
	// Model update on the rising edge
	// ------------------------------
	always @(posedge Clk)
	begin
		if (!rst_n)
		begin
			seen_reset <= 1'b1;
			st <= S_INTRO;
			song <= 0;
			step <= 0;
		end
		else
		begin
			case (st)
				S_INTRO: st <= S_READY;
				S_READY:
					if (one || two)
					begin
						// One has priority over two
						st <= S_PLAY;
						song <= one ? 0 : 1;
						step <= 0;
					end
				S_PLAY:
					if (shift && step == `SONG_STEPS - 1)
					begin
						st <= S_TAIL;
						step <= 0;
					end
					else if (shift)
						step <= step + 1;
				S_TAIL:
					if (shift && step == `TAIL_STEPS - 1)
					begin
						st <= S_HOLD;
						step <= 0;
					end
					else if (shift)
						step <= step + 1;
				S_HOLD:
					if (space)
						st <= S_RELEASE;
				default:
					if (!space)
						st <= S_READY;
			endcase
		end
	end

	// ------------------------------
	// Output comparison, falling edge
	// ------------------------------
	always @(negedge Clk)
	begin
		if (seen_reset)
		begin
			compare_value("lane1_trig", 32'(expected_lane(1)), 32'(lane1_trig));
			compare_value("lane2_trig", 32'(expected_lane(2)), 32'(lane2_trig));
			compare_value("lane3_trig", 32'(expected_lane(3)), 32'(lane3_trig));
			compare_value("lane4_trig", 32'(expected_lane(4)), 32'(lane4_trig));
			compare_value("intro", 32'(st == S_INTRO), 32'(intro));
			compare_value("ready", 32'(st == S_READY), 32'(ready));
			compare_value("song_start", 32'(st == S_PLAY && step == 0), 32'(song_start));
			compare_value("game_over", 32'(st == S_HOLD || st == S_RELEASE), 32'(game_over));
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_rhythm.sv ====
// Testbench top for the note sequencer
// Clock, reset, directed songs and a random run, inputs driven 1 ns after the edge
// rhythm_checker compares every cycle, this module prints the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_rhythm;
	import chart_pkg::*;

	logic Clk = 1'b0;
	logic rst_n;
	logic shift;
	logic space;
	logic one;
	logic two;
	lane_trig_t lane1_trig;
	lane_trig_t lane2_trig;
	lane_trig_t lane3_trig;
	lane_trig_t lane4_trig;
	logic intro;
	logic ready;
	logic song_start;
	logic game_over;
	int test_id;
	int check_count;
	int error_count;
	int timeouts;
	logic [31:0] rand_state;

	// 10 ns clock
	always #5 Clk = ~Clk;

	rhythm_top dut (.*);

	rhythm_checker chk (.*);

	// LCG, upper half used
	function automatic int rand_below(input int n);
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return int'((rand_state >> 16) % 32'(n));
	endfunction

	task automatic next_cycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && n < 50)
		begin
			next_cycle();
			n++;
		end
		if (!ready)
		begin
			timeouts++;
			$display("Timeout: ready did not rise within 50 cycles");
		end
	endtask

	// Press the song buttons for one cycle from the ready screen
	task automatic start_song(input logic press_one, input logic press_two);
		wait_ready();
		one = press_one;
		two = press_two;
		next_cycle();
		one = 1'b0;
		two = 1'b0;
	endtask

	// Song and tail steps, random idle gaps between shifts
	task automatic play_through(input int max_gap);
		int gap;
		for (int s = 0; s < `SONG_STEPS + `TAIL_STEPS; s++)
		begin
			gap = rand_below(max_gap + 1);
			repeat (gap) next_cycle();
			shift = 1'b1;
			next_cycle();
			shift = 1'b0;
		end
	endtask

	// End screen holds until space is pressed and let go
	task automatic end_screen();
		int n;
		n = 0;
		while (!game_over && n < 20)
		begin
			next_cycle();
			n++;
		end
		if (!game_over)
		begin
			timeouts++;
			$display("Timeout: game_over did not rise within 20 cycles");
		end
		repeat (1 + rand_below(4)) next_cycle();
		space = 1'b1;
		repeat (1 + rand_below(3)) next_cycle();
		space = 1'b0;
		wait_ready();
	endtask

	task automatic random_run(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			shift = (rand_below(2) == 0);
			space = (rand_below(4) == 0);
			one = (rand_below(8) == 0);
			two = (rand_below(8) == 0);
			next_cycle();
		end
		shift = 1'b0;
		space = 1'b0;
		one = 1'b0;
		two = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		shift = 1'b0;
		space = 1'b0;
		one = 1'b0;
		two = 1'b0;
		test_id = 0;
		timeouts = 0;
		rand_state = 32'h61be;

		// Reset for two rising edges, then intro then ready
		repeat (2) @(posedge Clk);
		#1;
		rst_n = 1'b1;
		wait_ready();

		test_id = 1;
		start_song(1'b1, 1'b0);
		play_through(3);
		end_screen();

		// Song 2 with back to back shifts mixed in
		test_id = 2;
		start_song(1'b0, 1'b1);
		play_through(2);
		end_screen();

		test_id = 3;
		start_song(1'b1, 1'b1);
		play_through(1);
		end_screen();

		test_id = 4;
		random_run(4000);
		repeat (2) next_cycle();

		$display("Checks: %0d  mismatches: %0d  timeouts: %0d",
			check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0 && check_count > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/sequencer_pkg.sv
src/chart_pkg.sv
src/sequence_if.sv
src/game_fsm.sv
src/step_counter.sv
src/note_chart.sv
src/rhythm_top.sv
verif/rhythm_checker.sv
verif/tb_rhythm.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the note sequencer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rhythm -f vlog.f \
	|| { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_rhythm)" || { echo "$sim_out"; echo "Simulation aborted"; exit 1; }
echo "$sim_out"
echo "$sim_out" | grep -qF "All tests passed" && exit 0 || exit 1
